// File: run.sh
#!/usr/bin/env bash
# Build the AXI write master testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f tb.f --top-module tb_axi_write_master -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: src/axi_wr_pkg.sv
////////////////////////////////////////////////////////////
// Widths, burst constants and bus structs for the AXI4
// write master. The data bus is fixed at 32 bits, and a
// burst never spans more than 1 KB of address space
////////////////////////////////////////////////////////////
package axi_wr_pkg;

  //////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int XFER_W       = 32;
  localparam int DW_BYTES     = DATA_W / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  // Burst shape, capped by the 4 KB rule and by 256 beats
  localparam int BURST_LEN     = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST_LEN = $clog2(BURST_LEN);
  localparam int BURST_BYTES   = BURST_LEN * DW_BYTES;
  localparam logic [ADDR_W-1:0] BURST_MASK = ADDR_W'(BURST_BYTES - 1);

  // Beat count width, then what is left above one burst
  localparam int BEAT_W = XFER_W - LOG_DW_BYTES;
  localparam int TXN_W  = BEAT_W - LOG_BURST_LEN;

  // Outstanding and pending burst tracking
  localparam int MAX_OUTSTANDING = 4;
  localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1);
  localparam int PEND_W          = 8;

  //////////////////////////////////////////////////////////
  // Counter types
  //////////////////////////////////////////////////////////
  typedef logic [LOG_BURST_LEN-1:0] beat_cnt_t;
  typedef logic [TXN_W-1:0]         txn_cnt_t;
  typedef logic [PEND_W-1:0]        pend_cnt_t;
  typedef logic [OUTST_W-1:0]       outst_cnt_t;

  // Request as sampled on ctrl_start
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [XFER_W-1:0] size;
  } wr_req_t;

  // Derived transfer shape, steady from start to next request
  typedef struct packed {
    logic [ADDR_W-1:0]   base_addr;
    txn_cnt_t            num_txn;
    beat_cnt_t           final_len;
    logic [DW_BYTES-1:0] final_strb;
    logic                single_txn;
  } xfer_plan_t;

  // AW payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } aw_chan_t;

  // W payload
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DW_BYTES-1:0] strb;
    logic                last;
  } w_chan_t;

endpackage

// File: src/axi_write_master.sv
////////////////////////////////////////////////////////////
// AXI4 write master top. Stream words go to memory from a
// 1 KB aligned base, in bursts of up to 256 beats, with at
// most MAX_OUTSTANDING bursts awaiting a response
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module axi_write_master import axi_wr_pkg::*; (
  input  logic              aclk,
  input  logic              areset,
  // Control
  input  logic              ctrl_start,
  input  wr_req_t           ctrl_req,
  output logic              ctrl_done,
  // Stream in
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  logic [DATA_W-1:0] s_axis_tdata,
  // AW
  output logic              m_axi_awvalid,
  input  logic              m_axi_awready,
  output aw_chan_t          m_axi_aw,
  // W
  output logic              m_axi_wvalid,
  input  logic              m_axi_wready,
  output w_chan_t           m_axi_w,
  // B
  input  logic              m_axi_bvalid,
  output logic              m_axi_bready
);

  logic       start;
  xfer_plan_t plan;
  logic       burst_first;
  logic       stall;
  logic       aw_fire;

  xfer_planner u_planner (
    .aclk       (aclk),
    .areset     (areset),
    .ctrl_start (ctrl_start),
    .ctrl_req   (ctrl_req),
    .start      (start),
    .plan       (plan)
  );

  // Data leads, the address channel follows each burst's first beat
  wdata_channel u_wdata (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .plan          (plan),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_wready  (m_axi_wready),
    .s_axis_tready (s_axis_tready),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_w       (m_axi_w),
    .burst_first   (burst_first)
  );

  waddr_channel u_waddr (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .plan          (plan),
    .burst_first   (burst_first),
    .stall         (stall),
    .m_axi_awready (m_axi_awready),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_aw      (m_axi_aw),
    .aw_fire       (aw_fire)
  );

  wresp_tracker u_wresp (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .aw_fire      (aw_fire),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .stall        (stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

// File: src/updown_counter.sv
////////////////////////////////////////////////////////////
// Loadable up/down counter with a zero flag. Load wins,
// incr with decr together holds, and the count wraps freely
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module updown_counter #(
  parameter type    count_t = logic [7:0],
  parameter count_t INIT    = '0
) (
  input  logic   aclk,
  input  logic   areset,
  input  logic   load,
  input  logic   incr,
  input  logic   decr,
  input  count_t load_value,
  output count_t count,
  output logic   is_zero
);

  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + count_t'(1);
    end else if (decr && !incr) begin
      // Wraps from zero to all ones
      count <= count - count_t'(1);
    end
  end

  // Zero flag straight from the count
  assign is_zero = (count == count_t'(0));

endmodule

// File: src/waddr_channel.sv
////////////////////////////////////////////////////////////
// Issues one AW transfer per burst, always after that
// burst's first data beat. Address steps by 1 KB, and the
// payload holds while awvalid waits
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module waddr_channel import axi_wr_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  xfer_plan_t plan,
  input  logic       burst_first,
  input  logic       stall,
  input  logic       m_axi_awready,
  output logic       m_axi_awvalid,
  output aw_chan_t   m_axi_aw,
  output logic       aw_fire
);

  logic              idle;
  logic              aw_final;
  logic              awvalid_r;
  logic [ADDR_W-1:0] addr_r;

  assign m_axi_awvalid = awvalid_r;
  assign aw_fire       = awvalid_r & m_axi_awready;

  //////////////////////////////////////////////////////////
  // Bursts with data started but no address yet
  //////////////////////////////////////////////////////////
  updown_counter #(
    .count_t (pend_cnt_t),
    .INIT    (pend_cnt_t'(0))
  ) u_pend_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_first),
    .decr       (aw_fire),
    .load_value (pend_cnt_t'(0)),
    .count      (),
    .is_zero    (idle)
  );

  // Address bursts left, zero flags the final one
  updown_counter #(
    .count_t (txn_cnt_t),
    .INIT    (txn_cnt_t'(0))
  ) u_aw_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (aw_fire),
    .load_value (plan.num_txn),
    .count      (),
    .is_zero    (aw_final)
  );

  //////////////////////////////////////////////////////////
  // AW valid and payload
  //////////////////////////////////////////////////////////
  // Raise a cycle after a pending burst appears with room to go
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!idle && !awvalid_r && !stall) begin
      awvalid_r <= 1'b1;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= plan.base_addr;
    end else if (aw_fire) begin
      addr_r <= addr_r + ADDR_W'(BURST_BYTES);
    end
  end

  always_comb begin
    m_axi_aw.addr = addr_r;
    m_axi_aw.len  = aw_final ? plan.final_len : 8'(BURST_LEN - 1);
  end

endmodule

// File: src/wdata_channel.sv
////////////////////////////////////////////////////////////
// Feeds the stream straight onto the W channel. Stream
// back-pressure is W back-pressure, and nothing passes
// until start has armed the running flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module wdata_channel import axi_wr_pkg::*; (
  input  logic              aclk,
  input  logic              areset,
  input  logic              start,
  input  xfer_plan_t        plan,
  input  logic              s_axis_tvalid,
  input  logic [DATA_W-1:0] s_axis_tdata,
  input  logic              m_axi_wready,
  output logic              s_axis_tready,
  output logic              m_axi_wvalid,
  output w_chan_t           m_axi_w,
  output logic              burst_first
);

  logic     running;
  logic     wxfer;
  logic     wlast;
  logic     final_burst;
  logic     almost_final;
  logic     final_xfer;
  logic     load_beats;
  logic     wfirst;
  logic     first_offered;
  txn_cnt_t bursts_left;

  //////////////////////////////////////////////////////////
  // Handshake gating
  //////////////////////////////////////////////////////////
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign wxfer         = m_axi_wvalid & m_axi_wready;

  // Last beat of the last burst ends the transfer
  assign final_xfer = wxfer & wlast & final_burst;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////
  // Beat and burst countdowns
  //////////////////////////////////////////////////////////
  assign almost_final = (bursts_left == txn_cnt_t'(1));
  // Short final burst reloads here, full bursts just wrap through 255
  assign load_beats = (wxfer & wlast & almost_final) | (start & plan.single_txn);

  updown_counter #(
    .count_t (beat_cnt_t),
    .INIT    (beat_cnt_t'(BURST_LEN - 1))
  ) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (plan.final_len),
    .count      (),
    .is_zero    (wlast)
  );

  updown_counter #(
    .count_t (txn_cnt_t),
    .INIT    (txn_cnt_t'(0))
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer & wlast),
    .load_value (plan.num_txn),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  // Partial strobe only on the very last beat
  always_comb begin
    m_axi_w.data = s_axis_tdata;
    m_axi_w.strb = (wlast && final_burst) ? plan.final_strb : '1;
    m_axi_w.last = wlast;
  end

  //////////////////////////////////////////////////////////
  // First-beat tracking
  //////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst        <= 1'b1;
      first_offered <= 1'b0;
      burst_first   <= 1'b0;
    end else begin
      // Next beat opens a burst once wlast has gone through
      if (wxfer) begin
        wfirst <= wlast;
      end
      if (wxfer) begin
        first_offered <= 1'b0;
      end else if (m_axi_wvalid && wfirst) begin
        first_offered <= 1'b1;
      end
      // One pulse per burst, however long its opening beat waits
      burst_first <= m_axi_wvalid & wfirst & ~first_offered;
    end
  end

endmodule

// File: src/wresp_tracker.sv
////////////////////////////////////////////////////////////
// Takes B responses, caps bursts awaiting a response at
// MAX_OUTSTANDING and pulses done after the last one.
// bready is tied high and bresp is not checked
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module wresp_tracker import axi_wr_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       start,
  input  xfer_plan_t plan,
  input  logic       aw_fire,
  input  logic       m_axi_bvalid,
  output logic       m_axi_bready,
  output logic       stall,
  output logic       ctrl_done
);

  logic bxfer;
  logic b_final;

  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;

  // Responses still to come, zero on the final one
  updown_counter #(
    .count_t (txn_cnt_t),
    .INIT    (txn_cnt_t'(0))
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (bxfer),
    .load_value (plan.num_txn),
    .count      (),
    .is_zero    (b_final)
  );

  // Free slots for address issue, empty means stall
  updown_counter #(
    .count_t (outst_cnt_t),
    .INIT    (outst_cnt_t'(MAX_OUTSTANDING))
  ) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (aw_fire),
    .load_value (outst_cnt_t'(0)),
    .count      (),
    .is_zero    (stall)
  );

  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= bxfer & b_final;
    end
  end

endmodule

// File: src/xfer_planner.sv
////////////////////////////////////////////////////////////
// Captures a write request and derives the burst plan.
// Base is forced to a 1 KB boundary and a size of zero
// is not supported
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module xfer_planner import axi_wr_pkg::*; (
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  wr_req_t    ctrl_req,
  output logic       start,
  output xfer_plan_t plan
);

  logic [ADDR_W-1:0]       base_r;
  logic [BEAT_W-1:0]       beats_m1_r;
  logic [LOG_DW_BYTES-1:0] rem_r;
  logic                    start_d1;
  beat_cnt_t               final_len_r;
  logic [DW_BYTES-1:0]     final_strb_r;

  //////////////////////////////////////////////////////////
  // Request capture
  //////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      base_r <= ctrl_req.addr & ~BURST_MASK;
      rem_r  <= ctrl_req.size[LOG_DW_BYTES-1:0];
      // Partial beat rounds up, so beats minus one is the plain quotient
      if (ctrl_req.size[LOG_DW_BYTES-1:0] != '0) begin
        beats_m1_r <= ctrl_req.size[XFER_W-1:LOG_DW_BYTES];
      end else begin
        beats_m1_r <= ctrl_req.size[XFER_W-1:LOG_DW_BYTES] - 1'b1;
      end
    end
  end

  // Start strobe trails ctrl_start by two cycles
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

  // Final length and strobe settle on the same edge as start
  always_ff @(posedge aclk) begin
    final_len_r <= beats_m1_r[LOG_BURST_LEN-1:0];
    for (int i = 0; i < DW_BYTES; i++) begin
      // Remainder of zero means a full final beat
      final_strb_r[i] <= (rem_r == '0) || (i < int'(rem_r));
    end
  end

  //////////////////////////////////////////////////////////
  // Plan out
  //////////////////////////////////////////////////////////
  always_comb begin
    plan.base_addr  = base_r;
    plan.num_txn    = beats_m1_r[BEAT_W-1:LOG_BURST_LEN];
    plan.final_len  = final_len_r;
    plan.final_strb = final_strb_r;
    plan.single_txn = (beats_m1_r[BEAT_W-1:LOG_BURST_LEN] == '0);
  end

endmodule

// File: tb.f
src/axi_wr_pkg.sv
src/updown_counter.sv
src/xfer_planner.sv
src/wdata_channel.sv
src/waddr_channel.sv
src/wresp_tracker.sv
src/axi_write_master.sv
testbench/tb_axi_write_master.sv

// File: testbench/tb_axi_write_master.sv
////////////////////////////////////////////////////////////
// Directed testbench for the AXI4 write master. The slave
// model answers each burst once its AW and wlast are both
// seen. One transfer runs at a time, and sizes stay small
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_axi_write_master import axi_wr_pkg::*;;

  localparam int CLK_PERIOD      = 20;
  // Beats of tests 2 to 6
  localparam int TOTAL_BEATS     = 4 + 650 + 525 + 1500 + 150;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 2000;

  logic              aclk;
  logic              areset;
  logic              ctrl_start;
  wr_req_t           ctrl_req;
  logic              ctrl_done;
  logic              s_axis_tvalid = 1'b0;
  logic              s_axis_tready;
  logic [DATA_W-1:0] s_axis_tdata  = '0;
  logic              m_axi_awvalid;
  logic              m_axi_awready = 1'b1;
  aw_chan_t          m_axi_aw;
  logic              m_axi_wvalid;
  logic              m_axi_wready  = 1'b1;
  w_chan_t           m_axi_w;
  logic              m_axi_bvalid  = 1'b0;
  logic              m_axi_bready;

  // Test controls
  integer seed         = 28;
  logic   backpressure = 1'b0;
  logic   hold_b       = 1'b0;
  logic   idle_valid   = 1'b0;

  // Reference of the running transfer
  logic [ADDR_W-1:0] exp_addr   = '0;
  int                exp_size   = 0;
  int                exp_beats  = 0;
  int                exp_bursts = 0;

  // Bus model tallies
  int       aw_count     = 0;
  int       w_count      = 0;
  int       last_count   = 0;
  int       b_count      = 0;
  int       done_count   = 0;
  int       src_idx      = 0;
  int       offered_cnt  = 0;
  int       b_delay      = 0;
  int       b_gap        = 2;
  logic     final_b_prev = 1'b0;
  logic     aw_wait      = 1'b0;
  aw_chan_t aw_held;
  logic [ADDR_W-1:0]   first_aw_addr;
  logic [7:0]          first_aw_len;
  logic [DW_BYTES-1:0] last_strb;

  int mismatch_count = 0;
  int failure_count  = 0;

  axi_write_master dut (
    .aclk          (aclk),
    .areset        (areset),
    .ctrl_start    (ctrl_start),
    .ctrl_req      (ctrl_req),
    .ctrl_done     (ctrl_done),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_aw      (m_axi_aw),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_w       (m_axi_w),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready)
  );

  initial begin : clock_gen
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic flag_failure(input string what);
    failure_count++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////
  // Stream word k is unique within a transfer
  function automatic logic [31:0] data_word(input int k);
    return (32'(k) * 32'h0001_0001) ^ 32'hA5A5_0000;
  endfunction

  // wlast every 256 beats and on the final beat
  function automatic logic exp_last(input int k);
    return ((k % BURST_LEN) == BURST_LEN - 1) || (k == exp_beats - 1);
  endfunction

  function automatic logic [3:0] exp_strb(input int k);
    int rem;
    rem = exp_size % DW_BYTES;
    if (k != exp_beats - 1 || rem == 0) begin
      return 4'hF;
    end
    return 4'((1 << rem) - 1);
  endfunction

  function automatic logic [31:0] exp_aw_addr(input int j);
    return (exp_addr & ~32'(BURST_BYTES - 1)) + 32'(j * BURST_BYTES);
  endfunction

  function automatic logic [7:0] exp_aw_len(input int j);
    if (j == exp_bursts - 1) begin
      return 8'((exp_beats - 1) % BURST_LEN);
    end
    return 8'(BURST_LEN - 1);
  endfunction

  //////////////////////////////////////////////////////////
  // Slave model, stream source and bus monitor
  //////////////////////////////////////////////////////////
  initial begin : bus_model
    logic b_fire;
    logic final_b_now;
    int   avail;
    forever begin
      @(posedge aclk);
      b_fire      = m_axi_bvalid && m_axi_bready;
      final_b_now = 1'b0;
      if (!areset) begin
        // Done comes one cycle after the final response and at no other time
        if (ctrl_done !== final_b_prev) begin
          flag_mismatch("ctrl_done", ctrl_done, final_b_prev);
        end
        if (ctrl_done) begin
          done_count++;
        end
        // Responses are never refused
        if (m_axi_bready !== 1'b1) begin
          flag_mismatch("m_axi_bready", m_axi_bready, 1'b1);
        end
        // AW must hold valid and payload until accepted
        if (aw_wait && !m_axi_awvalid) begin
          flag_failure("awvalid dropped before awready");
        end else if (aw_wait && m_axi_aw !== aw_held) begin
          flag_failure("AW payload changed while awvalid waited");
        end
        if (m_axi_awvalid && m_axi_awready) begin
          if (aw_count >= offered_cnt) begin
            flag_failure("AW issued before its first data beat was offered");
          end
          if (aw_count >= exp_bursts) begin
            flag_failure("more AW transfers than bursts");
          end
          if (m_axi_aw.addr !== exp_aw_addr(aw_count)) begin
            flag_mismatch("m_axi_aw.addr", m_axi_aw.addr, exp_aw_addr(aw_count));
          end
          if (m_axi_aw.len !== exp_aw_len(aw_count)) begin
            flag_mismatch("m_axi_aw.len", m_axi_aw.len, exp_aw_len(aw_count));
          end
          if (aw_count == 0) begin
            first_aw_addr = m_axi_aw.addr;
            first_aw_len  = m_axi_aw.len;
          end
          aw_count++;
        end
        aw_wait = m_axi_awvalid && !m_axi_awready;
        aw_held = m_axi_aw;
        // Burst of the beat now on the bus counts as offered
        if (m_axi_wvalid && (w_count / BURST_LEN + 1) > offered_cnt) begin
          offered_cnt = w_count / BURST_LEN + 1;
        end
        if (m_axi_wvalid && m_axi_wready) begin
          if (w_count >= exp_beats) begin
            flag_failure("data beat beyond the end of the transfer");
          end
          if (m_axi_w.data !== data_word(w_count)) begin
            flag_mismatch("m_axi_w.data", m_axi_w.data, data_word(w_count));
          end
          if (m_axi_w.last !== exp_last(w_count)) begin
            flag_mismatch("m_axi_w.last", m_axi_w.last, exp_last(w_count));
          end
          if (m_axi_w.strb !== exp_strb(w_count)) begin
            flag_mismatch("m_axi_w.strb", m_axi_w.strb, exp_strb(w_count));
          end
          if (m_axi_w.last) begin
            last_count++;
          end
          last_strb = m_axi_w.strb;
          w_count++;
        end
        if (s_axis_tvalid && s_axis_tready) begin
          src_idx++;
        end
        if (b_fire) begin
          b_count++;
          final_b_now = (b_count == exp_bursts);
        end
        if (aw_count - b_count > MAX_OUTSTANDING) begin
          flag_failure("more than MAX_OUTSTANDING bursts await a response");
        end
      end
      final_b_prev = final_b_now;

      // Next cycle's drive
      s_axis_tvalid <= idle_valid || (src_idx < exp_beats);
      s_axis_tdata  <= data_word(src_idx);
      if (backpressure) begin
        m_axi_wready  <= ($random(seed) & 3) != 0;
        m_axi_awready <= ($random(seed) & 1) != 0;
      end else begin
        m_axi_wready  <= 1'b1;
        m_axi_awready <= 1'b1;
      end
      // A burst is complete once its AW and its wlast have both passed
      avail = ((aw_count < last_count) ? aw_count : last_count) - b_count;
      if (b_fire || !m_axi_bvalid) begin
        if (avail > 0 && !hold_b && b_delay >= b_gap) begin
          m_axi_bvalid <= 1'b1;
          b_delay = 0;
          b_gap   = backpressure ? 2 + ($random(seed) & 7) : 2;
        end else begin
          m_axi_bvalid <= 1'b0;
          if (avail > 0) begin
            b_delay++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////
  // Transfer helpers
  //////////////////////////////////////////////////////////
  task automatic launch_transfer(input logic [ADDR_W-1:0] addr, input int size);
    @(negedge aclk);
    exp_addr    = addr;
    exp_size    = size;
    exp_beats   = (size + DW_BYTES - 1) / DW_BYTES;
    exp_bursts  = (exp_beats + BURST_LEN - 1) / BURST_LEN;
    aw_count    = 0;
    w_count     = 0;
    last_count  = 0;
    b_count     = 0;
    done_count  = 0;
    src_idx     = 0;
    offered_cnt = 0;
    b_delay     = 0;
    @(posedge aclk);
    ctrl_req.addr <= addr;
    ctrl_req.size <= 32'(size);
    ctrl_start    <= 1'b1;
    @(posedge aclk);
    ctrl_start <= 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int cycles;
    cycles = 0;
    while (done_count == 0 && cycles < limit) begin
      @(negedge aclk);
      cycles++;
    end
    if (done_count == 0) begin
      flag_failure("timed out waiting for ctrl_done");
    end
    repeat (10) @(negedge aclk);
  endtask

  task automatic check_totals();
    if (aw_count != exp_bursts) begin
      flag_mismatch("AW transfer count", aw_count, exp_bursts);
    end
    if (w_count != exp_beats) begin
      flag_mismatch("W beat count", w_count, exp_beats);
    end
    if (last_count != exp_bursts) begin
      flag_mismatch("wlast count", last_count, exp_bursts);
    end
    if (b_count != exp_bursts) begin
      flag_mismatch("B response count", b_count, exp_bursts);
    end
    if (src_idx != exp_beats) begin
      flag_mismatch("stream words taken", src_idx, exp_beats);
    end
    if (done_count != 1) begin
      flag_mismatch("ctrl_done pulse count", done_count, 1);
    end
  endtask

  //////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////
  task automatic test_reset_state();
    $display("Test 1: reset state");
    @(negedge aclk);
    if (m_axi_awvalid !== 1'b0) begin
      flag_mismatch("m_axi_awvalid", m_axi_awvalid, 1'b0);
    end
    if (ctrl_done !== 1'b0) begin
      flag_mismatch("ctrl_done", ctrl_done, 1'b0);
    end
    // A stream offered before any start stays blocked
    idle_valid = 1'b1;
    repeat (4) begin
      @(negedge aclk);
      if (m_axi_wvalid !== 1'b0) begin
        flag_mismatch("m_axi_wvalid", m_axi_wvalid, 1'b0);
      end
      if (s_axis_tready !== 1'b0) begin
        flag_mismatch("s_axis_tready", s_axis_tready, 1'b0);
      end
    end
    idle_valid = 1'b0;
    @(negedge aclk);
  endtask

  task automatic test_small_unaligned();
    $display("Test 2: small unaligned transfer");
    launch_transfer(32'h0000_1234, 13);
    wait_done(500);
    check_totals();
    if (first_aw_addr !== 32'h0000_1000) begin
      flag_mismatch("m_axi_aw.addr", first_aw_addr, 32'h0000_1000);
    end
    if (first_aw_len !== 8'd3) begin
      flag_mismatch("m_axi_aw.len", first_aw_len, 8'd3);
    end
    if (last_strb !== 4'b0001) begin
      flag_mismatch("m_axi_w.strb", last_strb, 4'b0001);
    end
  endtask

  task automatic test_multi_burst();
    $display("Test 3: multi-burst transfer");
    launch_transfer(32'h0004_0000, 2600);
    wait_done(650 * 8 + 500);
    check_totals();
    if (first_aw_len !== 8'd255) begin
      flag_mismatch("m_axi_aw.len", first_aw_len, 8'd255);
    end
  endtask

  task automatic test_backpressure();
    $display("Test 4: back-pressure");
    backpressure = 1'b1;
    launch_transfer(32'h0010_0400, 2100);
    wait_done(525 * 8 + 500);
    check_totals();
    backpressure = 1'b0;
  endtask

  task automatic test_outstanding_limit();
    int cycles;
    $display("Test 5: outstanding limit");
    hold_b = 1'b1;
    launch_transfer(32'h0020_0000, 6000);
    cycles = 0;
    while (w_count < exp_beats && cycles < 1500 * 8) begin
      @(negedge aclk);
      cycles++;
    end
    if (w_count < exp_beats) begin
      flag_failure("timed out waiting for the data beats");
    end
    repeat (20) @(negedge aclk);
    // Address issue stalls at the limit while responses are held
    if (aw_count != MAX_OUTSTANDING) begin
      flag_mismatch("AW transfer count", aw_count, MAX_OUTSTANDING);
    end
    if (m_axi_awvalid !== 1'b0) begin
      flag_mismatch("m_axi_awvalid", m_axi_awvalid, 1'b0);
    end
    hold_b = 1'b0;
    wait_done(1000);
    check_totals();
  endtask

  task automatic test_done_pulse();
    $display("Test 6: done pulse");
    backpressure = 1'b1;
    launch_transfer(32'h0030_0000, 600);
    wait_done(150 * 8 + 500);
    repeat (20) @(negedge aclk);
    check_totals();
    backpressure = 1'b0;
  endtask

  initial begin : main
    areset     = 1'b1;
    ctrl_start = 1'b0;
    ctrl_req   = '0;
    repeat (5) @(posedge aclk);
    areset <= 1'b0;
    test_reset_state();
    test_small_unaligned();
    test_multi_burst();
    test_backpressure();
    test_outstanding_limit();
    test_done_pulse();
    $display("Summary: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count + failure_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
